// ==== apb_periph.f ====
periph_bus_pkg.sv
periph_map_pkg.sv
apb_reg_bank.sv
apb_timer.sv
apb_pwm.sv
apb_fabric.sv
apb_periph_top.sv
tb_clock_gen.sv
tb_apb_periph.sv

// ==== Makefile ====
# Verilator flow for the APB peripheral subsystem; any variable can be set on the command line
VERILATOR  ?= verilator
TOP        ?= tb_apb_periph
RTL_TOP    ?= apb_periph_top
FLIST      ?= apb_periph.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides the result
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed, log in $(LOG)"; \
	else \
		echo "simulation failed, log in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_apb_periph.sv ====
// Self-checking APB testbench; inputs change 1 ns after rising edges, halts at the first failure
`timescale 1ns/1ps

module tb_apb_periph;
   import periph_bus_pkg::*;
   import periph_map_pkg::*;

   localparam int MAX_WAIT = 1024;   // Cycles allowed for any wait loop
   localparam logic [APB_ADDR_W-1:0] TIMER_STAT = {TIMER_SLOT, TIMER_STATUS_OFS};
   localparam logic [APB_ADDR_W-1:0] PWM_STAT   = {PWM_SLOT, PWM_STATUS_OFS};

   logic                  clk;
   logic                  rst_n;
   apb_req_t              req;
   apb_rsp_t              rsp;
   logic                  timer_irq;
   logic                  pwm;
   logic [31:0]           rng_q;
   logic [APB_ADDR_W-1:0] cfg_addr [5];   // Timer ctrl, compare, PWM ctrl, period, duty
   logic [APB_DATA_W-1:0] shadow [5];

   tb_clock_gen #(
      .PERIOD_NS  (10),
      .RST_CYCLES (16)
   ) u_clk (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   apb_periph_top #(
      .TIMER_CNT_W (32),
      .PWM_CNT_W   (8)    // Small PWM counter
   ) dut_i (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .apb_req_i   (req),
      .apb_rsp_o   (rsp),
      .timer_irq_o (timer_irq),
      .pwm_o       (pwm)
   );

   //**************************************************
   // Helpers
   //**************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_q = xorshift32(rng_q);
      return rng_q;
   endfunction

   task automatic report_fail(input string what);
      $display("%s", what);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp)
         else report_fail($sformatf("FAILED %s: got %h expected %h", name, got, exp));
   endtask

   // Setup then access, response sampled mid-cycle
   task automatic apb_xfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, input logic exp_err,
                           output logic [31:0] rdata);
      int waits = 0;
      @(posedge clk) #1;
      req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(posedge clk) #1;
      req.penable = 1'b1;
      @(negedge clk);
      while (!rsp.pready) begin
         if (waits == MAX_WAIT) begin
            report_fail($sformatf("no pready for the transfer to address %h", addr));
         end
         waits++;
         @(negedge clk);
      end
      rdata = rsp.prdata;
      check_value($sformatf("apb_rsp_o.pslverr at %h", addr), 32'(rsp.pslverr), 32'(exp_err));
      @(posedge clk) #1;
      req = APB_REQ_IDLE;
   endtask

   task automatic check_read(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp,
                             input logic exp_err);
      logic [31:0] rdata;
      apb_xfer(1'b0, addr, '0, exp_err, rdata);
      check_value($sformatf("apb_rsp_o.prdata at %h", addr), rdata, exp);
   endtask

   task automatic check_bad_access(input logic [APB_ADDR_W-1:0] addr);
      logic [31:0] rdata;
      check_read(addr, '0, 1'b1);
      apb_xfer(1'b1, addr, next_rand(), 1'b1, rdata);
   endtask

   // Cycles from now to the next negedge with timer_irq_o high
   task automatic measure_irq_gap(output int gap);
      gap = 1;
      @(negedge clk);
      while (!timer_irq) begin
         if (gap == MAX_WAIT) begin
            report_fail("timer_irq_o never pulsed");
         end
         gap++;
         @(negedge clk);
      end
   endtask

   task automatic check_pwm(input int period, input int duty, input logic [31:0] ctrl);
      logic [31:0] rdata;
      int          highs;
      int          expect_highs;
      apb_xfer(1'b1, cfg_addr[3], 32'(period), 1'b0, rdata);
      apb_xfer(1'b1, cfg_addr[4], 32'(duty), 1'b0, rdata);
      apb_xfer(1'b1, cfg_addr[2], ctrl, 1'b0, rdata);
      expect_highs = ctrl[0] ? ((duty < period) ? duty : period) : 0;
      repeat (2 * period + 2) @(negedge clk);   // Settle into steady state
      highs = 0;
      for (int i = 0; i < period; i++) begin
         @(negedge clk);
         if (pwm) begin
            highs++;
         end
      end
      check_value("pwm_o high cycles per period", 32'(highs), 32'(expect_highs));
   endtask

   //**************************************************
   // Bus and interrupt checks
   //**************************************************
   a_access_ready : assert property (@(posedge clk) disable iff (!rst_n)
      (req.psel && req.penable) |-> rsp.pready)
      else report_fail($sformatf("FAILED apb_rsp_o.pready: got %h expected 1", rsp.pready));

   a_err_rdata_zero : assert property (@(posedge clk) disable iff (!rst_n)
      (req.psel && req.penable && !req.pwrite && rsp.pslverr) |-> (rsp.prdata == '0))
      else report_fail($sformatf("FAILED apb_rsp_o.prdata: got %h expected 0", rsp.prdata));

   a_irq_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
      timer_irq |=> !timer_irq)
      else report_fail("FAILED timer_irq_o: got 1 expected 0 on the cycle after a pulse");

   initial begin
      int          waits;
      int          cmp_val;
      int          gap;
      int          period;
      int          duty;
      logic [3:0]  slot;
      logic [31:0] rd;
      logic [31:0] cnt_a;
      logic [31:0] cnt_b;
      req         = APB_REQ_IDLE;
      rng_q       = 32'h6179;
      cfg_addr[0] = {TIMER_SLOT, TIMER_CTRL_OFS};
      cfg_addr[1] = {TIMER_SLOT, TIMER_CMP_OFS};
      cfg_addr[2] = {PWM_SLOT, PWM_CTRL_OFS};
      cfg_addr[3] = {PWM_SLOT, PWM_PERIOD_OFS};
      cfg_addr[4] = {PWM_SLOT, PWM_DUTY_OFS};
      waits = 0;
      while (!rst_n) begin
         if (waits == MAX_WAIT) begin
            report_fail("reset was never released");
         end
         waits++;
         @(posedge clk);
      end

      // Reset state
      check_value("timer_irq_o", 32'(timer_irq), '0);
      check_value("pwm_o", 32'(pwm), '0);
      for (int i = 0; i < 5; i++) begin
         check_read(cfg_addr[i], '0, 1'b0);
      end
      check_read(TIMER_STAT, '0, 1'b0);
      check_read(PWM_STAT, '0, 1'b0);

      // Readback, compare written before timer ctrl
      for (int i = 4; i >= 0; i--) begin
         shadow[i] = next_rand();
         apb_xfer(1'b1, cfg_addr[i], shadow[i], 1'b0, rd);
      end
      for (int i = 0; i < 5; i++) begin
         check_read(cfg_addr[i], shadow[i], 1'b0);
      end
      apb_xfer(1'b1, cfg_addr[0], '0, 1'b0, rd);
      apb_xfer(1'b1, cfg_addr[2], '0, 1'b0, rd);

      // Error responses
      slot = 4'(3 + next_rand() % 13);
      check_bad_access({4'd0, 8'h00});
      check_bad_access({slot, 8'(next_rand())});
      check_bad_access({TIMER_SLOT, 8'h0C});
      check_bad_access({TIMER_SLOT, 8'hFC});
      check_bad_access({PWM_SLOT, 8'h10});
      check_bad_access({PWM_SLOT, 8'hFC});
      apb_xfer(1'b1, TIMER_STAT, next_rand(), 1'b1, rd);
      apb_xfer(1'b1, PWM_STAT, next_rand(), 1'b1, rd);
      check_read(cfg_addr[1], shadow[1], 1'b0);   // Bad writes leave compare alone

      // Timer interrupt spacing
      cmp_val = 3 + int'(next_rand() % 8);
      apb_xfer(1'b1, cfg_addr[1], 32'(cmp_val), 1'b0, rd);
      apb_xfer(1'b1, cfg_addr[0], 32'h3, 1'b0, rd);
      measure_irq_gap(gap);   // First pulse, phase unknown
      for (int n = 0; n < 3; n++) begin
         measure_irq_gap(gap);
         check_value("timer_irq_o pulse spacing", 32'(gap), 32'(cmp_val + 1));
      end
      apb_xfer(1'b1, cfg_addr[0], 32'h1, 1'b0, rd);
      repeat (2) @(negedge clk);
      for (int n = 0; n < 3 * (cmp_val + 1); n++) begin
         @(negedge clk);
         check_value("timer_irq_o", 32'(timer_irq), '0);
      end

      // Timer hold
      apb_xfer(1'b1, cfg_addr[0], '0, 1'b0, rd);
      apb_xfer(1'b0, TIMER_STAT, '0, 1'b0, cnt_a);
      repeat (cmp_val) @(posedge clk);   // Reads end up cmp_val+3 cycles apart, off the wrap period
      apb_xfer(1'b0, TIMER_STAT, '0, 1'b0, cnt_b);
      check_value("timer count status", cnt_b, cnt_a);

      // PWM duty
      period = 4 + int'(next_rand() % 12);
      duty   = 1 + int'(next_rand() % 32'(period - 1));
      check_pwm(period, duty, 32'h1);
      check_pwm(period, period + 3, 32'h1);
      check_pwm(period, 0, 32'h1);
      check_pwm(period, duty, 32'h0);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== tb_clock_gen.sv ====
// Free-running clock from time zero; active-low reset released 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 16
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         clk_o = ~clk_o;
      end
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1;
      rst_n_o = 1'b1;   // Off the edge, no race with the flops
   end

endmodule

// ==== apb_periph_top.sv ====
// APB peripheral subsystem: timer in slot 1, PWM in slot 2, external master on apb_req_i
`timescale 1ns/1ps

module apb_periph_top #(
   parameter int TIMER_CNT_W = 32,
   parameter int PWM_CNT_W   = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  periph_bus_pkg::apb_req_t apb_req_i,
   output periph_bus_pkg::apb_rsp_t apb_rsp_o,
   output logic                     timer_irq_o,
   output logic                     pwm_o
);
   import periph_bus_pkg::*;

   apb_req_t timer_req;
   apb_rsp_t timer_rsp;
   apb_req_t pwm_req;
   apb_rsp_t pwm_rsp;

   apb_fabric u_fabric (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .apb_req_i   (apb_req_i),
      .apb_rsp_o   (apb_rsp_o),
      .timer_req_o (timer_req),
      .timer_rsp_i (timer_rsp),
      .pwm_req_o   (pwm_req),
      .pwm_rsp_i   (pwm_rsp)
   );

   apb_timer #(
      .CNT_W (TIMER_CNT_W)
   ) u_timer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (timer_req),
      .rsp_o   (timer_rsp),
      .irq_o   (timer_irq_o)
   );

   apb_pwm #(
      .CNT_W (PWM_CNT_W)
   ) u_pwm (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (pwm_req),
      .rsp_o   (pwm_rsp),
      .pwm_o   (pwm_o)
   );

endmodule

// ==== apb_fabric.sv ====
// Slot decoder for two APB slaves; empty slots answer with pslverr in the access cycle
`timescale 1ns/1ps

module apb_fabric (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  periph_bus_pkg::apb_req_t apb_req_i,
   output periph_bus_pkg::apb_rsp_t apb_rsp_o,
   output periph_bus_pkg::apb_req_t timer_req_o,
   input  periph_bus_pkg::apb_rsp_t timer_rsp_i,
   output periph_bus_pkg::apb_req_t pwm_req_o,
   input  periph_bus_pkg::apb_rsp_t pwm_rsp_i
);
   import periph_bus_pkg::*;
   import periph_map_pkg::*;

   logic [PERIPH_SLOT_W-1:0] slot;
   logic [APB_ADDR_W-1:0]    ofs_addr;
   logic                     hit_timer;
   logic                     hit_pwm;

   assign slot      = apb_req_i.paddr[APB_ADDR_W-1 -: PERIPH_SLOT_W];
   assign ofs_addr  = {{PERIPH_SLOT_W{1'b0}}, apb_req_i.paddr[PERIPH_OFS_W-1:0]};
   assign hit_timer = (slot == TIMER_SLOT);
   assign hit_pwm   = (slot == PWM_SLOT);

   //**************************************************
   // Request fan-out
   //**************************************************
   always_comb begin
      timer_req_o         = apb_req_i;
      timer_req_o.psel    = apb_req_i.psel & hit_timer;
      timer_req_o.penable = apb_req_i.penable & hit_timer;   // Keep slave idle
      timer_req_o.paddr   = ofs_addr;

      pwm_req_o           = apb_req_i;
      pwm_req_o.psel      = apb_req_i.psel & hit_pwm;
      pwm_req_o.penable   = apb_req_i.penable & hit_pwm;
      pwm_req_o.paddr     = ofs_addr;
   end

   // Response mux
   always_comb begin
      if (hit_timer) begin
         apb_rsp_o = timer_rsp_i;
      end else if (hit_pwm) begin
         apb_rsp_o = pwm_rsp_i;
      end else if (apb_req_i.psel && apb_req_i.penable) begin
         apb_rsp_o = APB_RSP_ERR;   // Nobody home
      end else begin
         apb_rsp_o = APB_RSP_IDLE;
      end
   end

   //**************************************************
   // Bus checks
   //**************************************************
   a_one_slave : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({timer_req_o.psel, pwm_req_o.psel})
   );

   a_setup_to_access : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (apb_req_i.psel && !apb_req_i.penable) |=>
         (apb_req_i.psel && apb_req_i.penable && $stable(apb_req_i.paddr) &&
          $stable(apb_req_i.pwrite) && $stable(apb_req_i.pwdata))
   );

endmodule

// ==== apb_pwm.sv ====
// Single-channel PWM, registered output; period and duty use their low CNT_W bits
`timescale 1ns/1ps

module apb_pwm #(
   parameter int CNT_W = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  periph_bus_pkg::apb_req_t req_i,
   output periph_bus_pkg::apb_rsp_t rsp_o,
   output logic                     pwm_o
);
   import periph_bus_pkg::*;
   import periph_map_pkg::*;

   pwm_cfg_t              cfg;
   logic [CNT_W-1:0]      period;
   logic [CNT_W-1:0]      duty;
   logic [CNT_W-1:0]      cnt_q;
   logic                  run;
   logic [APB_DATA_W-1:0] status;

   apb_reg_bank #(
      .cfg_t (pwm_cfg_t)
   ) u_regs (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (req_i),
      .rsp_o    (rsp_o),
      .status_i (status),
      .cfg_o    (cfg)
   );

   assign period = cfg.period[CNT_W-1:0];
   assign duty   = cfg.duty[CNT_W-1:0];
   assign run    = cfg.ctrl.en && (period != '0);
   assign status = APB_DATA_W'(cnt_q);

   //**************************************************
   // Period counter and output
   //**************************************************
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
         pwm_o <= 1'b0;
      end else begin
         pwm_o <= run && (cnt_q < duty);   // One cycle behind the counter
         if (!run) begin
            cnt_q <= '0;
         end else if (cnt_q >= period - 1'b1) begin
            cnt_q <= '0;   // Wrap, also after period shrinks
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // A period change gets one cycle to pull the counter back in range
   a_cnt_below_period : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (run && $stable(period)) |-> (cnt_q < period)
   );

endmodule

// ==== apb_timer.sv ====
// Compare-and-wrap timer with one-cycle irq pulse; CNT_W up to 32, compare uses its low CNT_W bits
`timescale 1ns/1ps

module apb_timer #(
   parameter int CNT_W = 32
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  periph_bus_pkg::apb_req_t req_i,
   output periph_bus_pkg::apb_rsp_t rsp_o,
   output logic                     irq_o
);
   import periph_bus_pkg::*;
   import periph_map_pkg::*;

   timer_cfg_t            cfg;
   logic [CNT_W-1:0]      cnt_q;
   logic [CNT_W-1:0]      cmp;
   logic                  wrap;
   logic [APB_DATA_W-1:0] status;

   apb_reg_bank #(
      .cfg_t (timer_cfg_t)
   ) u_regs (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (req_i),
      .rsp_o    (rsp_o),
      .status_i (status),
      .cfg_o    (cfg)
   );

   assign cmp    = cfg.compare[CNT_W-1:0];
   assign wrap   = (cnt_q >= cmp);   // Also recovers when compare drops below the count
   assign status = APB_DATA_W'(cnt_q);

   //**************************************************
   // Counter and interrupt
   //**************************************************
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
         irq_o <= 1'b0;
      end else if (cfg.ctrl.en) begin
         if (wrap) begin
            cnt_q <= '0;
            irq_o <= cfg.ctrl.irq_en;   // High while count reads zero
         end else begin
            cnt_q <= cnt_q + 1'b1;
            irq_o <= 1'b0;
         end
      end else begin
         irq_o <= 1'b0;   // Count holds
      end
   end

   // Back-to-back pulses only when every cycle is a wrap
   a_irq_single_pulse : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (irq_o && (cmp != '0)) |=> !irq_o
   );

endmodule

// ==== apb_reg_bank.sv ====
// Config words plus one read-only status word after them; cfg_t must be whole 32-bit words
`timescale 1ns/1ps

module apb_reg_bank #(
   parameter type cfg_t = logic [periph_bus_pkg::APB_DATA_W-1:0]
) (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  periph_bus_pkg::apb_req_t              req_i,
   output periph_bus_pkg::apb_rsp_t              rsp_o,
   input  logic [periph_bus_pkg::APB_DATA_W-1:0] status_i,
   output cfg_t                                  cfg_o
);
   import periph_bus_pkg::*;

   localparam int NUM_WORDS = $bits(cfg_t) / APB_DATA_W;
   localparam int IDX_W     = APB_ADDR_W - APB_BYTE_W;

   logic [NUM_WORDS-1:0][APB_DATA_W-1:0] cfg_q;
   logic [IDX_W-1:0]                     word_idx;
   logic                                 access;
   logic                                 is_cfg;
   logic                                 is_status;
   logic                                 err;
   logic [APB_DATA_W-1:0]                cfg_rdata;

   //**************************************************
   // Decode
   //**************************************************
   assign word_idx  = req_i.paddr[APB_ADDR_W-1:APB_BYTE_W];   // Byte lanes ignored
   assign access    = req_i.psel & req_i.penable;
   assign is_cfg    = (word_idx < IDX_W'(NUM_WORDS));
   assign is_status = (word_idx == IDX_W'(NUM_WORDS));

   // Status is read only, everything past it is unmapped
   assign err = !is_cfg && !(is_status && !req_i.pwrite);

   // Config storage, written on the edge ending the access phase
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg_q <= '0;
      end else if (access && req_i.pwrite && is_cfg) begin
         for (int w = 0; w < NUM_WORDS; w++) begin
            if (word_idx == IDX_W'(w)) begin
               cfg_q[w] <= req_i.pwdata;
            end
         end
      end
   end

   always_comb begin
      cfg_rdata = status_i;
      for (int w = 0; w < NUM_WORDS; w++) begin
         if (word_idx == IDX_W'(w)) begin
            cfg_rdata = cfg_q[w];
         end
      end
   end

   //**************************************************
   // Response, zero wait states
   //**************************************************
   assign rsp_o.pready  = access;
   assign rsp_o.pslverr = access & err;
   assign rsp_o.prdata  = (access && !req_i.pwrite && !err) ? cfg_rdata : '0;

   assign cfg_o = cfg_t'(cfg_q);

   // Fabric must drop penable together with psel for a slot it does not select
   a_penable_needs_psel : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      req_i.penable |-> req_i.psel
   );

endmodule

// ==== periph_map_pkg.sv ====
// Peripheral register map; each config struct is whole 32-bit words, word n at byte offset 4n
package periph_map_pkg;

   //**************************************************
   // Slot decode
   //**************************************************
   localparam int PERIPH_SLOT_W = 4;   // Top address bits pick a peripheral
   localparam int PERIPH_OFS_W  = periph_bus_pkg::APB_ADDR_W - PERIPH_SLOT_W;

   localparam logic [PERIPH_SLOT_W-1:0] TIMER_SLOT = 4'd1;
   localparam logic [PERIPH_SLOT_W-1:0] PWM_SLOT   = 4'd2;

   localparam logic [periph_bus_pkg::APB_ADDR_W-1:0] TIMER_BASE = {TIMER_SLOT, 8'h00};
   localparam logic [periph_bus_pkg::APB_ADDR_W-1:0] PWM_BASE   = {PWM_SLOT, 8'h00};

   // Byte offsets inside a slot
   localparam logic [PERIPH_OFS_W-1:0] TIMER_CTRL_OFS   = 8'h00;
   localparam logic [PERIPH_OFS_W-1:0] TIMER_CMP_OFS    = 8'h04;
   localparam logic [PERIPH_OFS_W-1:0] TIMER_STATUS_OFS = 8'h08;   // Count, read only

   localparam logic [PERIPH_OFS_W-1:0] PWM_CTRL_OFS     = 8'h00;
   localparam logic [PERIPH_OFS_W-1:0] PWM_PERIOD_OFS   = 8'h04;
   localparam logic [PERIPH_OFS_W-1:0] PWM_DUTY_OFS     = 8'h08;
   localparam logic [PERIPH_OFS_W-1:0] PWM_STATUS_OFS   = 8'h0C;   // Counter, read only

   //**************************************************
   // Configuration structs, last member is word 0
   //**************************************************
   typedef struct packed {
      logic [periph_bus_pkg::APB_DATA_W-3:0] rsvd;   // Read back as written
      logic                                  irq_en;
      logic                                  en;
   } timer_ctrl_t;

   typedef struct packed {
      logic [periph_bus_pkg::APB_DATA_W-1:0] compare;   // Word 1
      timer_ctrl_t                           ctrl;      // Word 0
   } timer_cfg_t;

   typedef struct packed {
      logic [periph_bus_pkg::APB_DATA_W-2:0] rsvd;
      logic                                  en;
   } pwm_ctrl_t;

   typedef struct packed {
      logic [periph_bus_pkg::APB_DATA_W-1:0] duty;     // Word 2
      logic [periph_bus_pkg::APB_DATA_W-1:0] period;   // Word 1
      pwm_ctrl_t                             ctrl;     // Word 0
   } pwm_cfg_t;

endpackage

// ==== periph_bus_pkg.sv ====
// APB bus shared by all peripherals: 32-bit data, 12-bit address, zero wait states, no strobes
package periph_bus_pkg;

   //**************************************************
   // Bus widths
   //**************************************************
   localparam int APB_ADDR_W = 12;   // One 4 KB window
   localparam int APB_DATA_W = 32;

   // Byte offset bits inside one data word
   localparam int APB_BYTE_W = $clog2(APB_DATA_W / 8);

   //**************************************************
   // Request from master, setup and access phase
   //**************************************************
   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [APB_ADDR_W-1:0] paddr;
      logic [APB_DATA_W-1:0] pwdata;
   } apb_req_t;

   // Response, sampled by the master in the access cycle only
   typedef struct packed {
      logic                  pready;
      logic                  pslverr;
      logic [APB_DATA_W-1:0] prdata;
   } apb_rsp_t;

   // Idle values, handy for tie-offs and reset of bus models
   localparam apb_req_t APB_REQ_IDLE = '0;
   localparam apb_rsp_t APB_RSP_IDLE = '0;

   // Response given by the fabric for an empty slot
   localparam apb_rsp_t APB_RSP_ERR = '{
      pready:  1'b1,
      pslverr: 1'b1,
      prdata:  '0
   };

endpackage
